/* bench/lsu_checker.sv */
// concurrent protocol assertions on the lsu memory and core ports, bound into lsu_top
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     req_valid_i,
  input logic     gnt_i,
  input mem_req_t req_i,
  input logic     resp_valid_i,
  input logic     rdata_valid_i,
  input logic     load_err_i,
  input logic     busy_i
);

  // a pending request keeps its payload until granted
  payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req_valid_i && !gnt_i) |=> (req_valid_i && $stable(req_i)))
    else $error("memory request dropped or changed before grant");

  be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_valid_i |-> (req_i.be != 4'b0000))
    else $error("memory request with no byte enabled");

  err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(load_err_i && rdata_valid_i))
    else $error("load error and read data valid at once");

  idle_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_valid_i |-> !busy_i)   // responses only come out of idle
    else $error("response while controller busy");

endmodule

bind lsu_top lsu_checker lsu_checker_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .req_valid_i   (mem_req_valid_o),
  .gnt_i         (mem_gnt_i),
  .req_i         (mem_req_o),
  .resp_valid_i  (lsu_resp_valid_o),
  .rdata_valid_i (lsu_rdata_valid_o),
  .load_err_i    (load_err_o),
  .busy_i        (busy_o)
);

/* bench/lsu_tb.sv */
// lsu testbench with clock, reset, LFSR, memory model, directed and random tests and result lines
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  logic     clk_i = 1'b0;
  logic     rst_ni;
  lsu_req_t lsu_req_i;
  logic     lsu_valid_i;
  logic     lsu_req_done_o;
  logic     lsu_resp_valid_o;
  logic     lsu_rdata_valid_o;
  word_t    lsu_rdata_o;
  logic     load_err_o;
  logic     store_err_o;
  addr_t    addr_last_o;
  logic     busy_o;
  logic     mem_req_valid_o;
  mem_req_t mem_req_o;
  logic     mem_gnt_i;
  logic     mem_rvalid_i;
  word_t    mem_rdata_i;
  logic     mem_err_i;

  logic [31:0] lfsr_state = 32'h5f98_0195;
  word_t       mem_words [16];
  logic [7:0]  ref_bytes [64];    // expected memory contents per byte
  int          cyc = 0;
  int          gnt_wait = 0;      // cycles of req left before gnt
  int          last_ready = 0;
  word_t       resp_data [$];
  logic        resp_err [$];
  int          resp_ready [$];    // cycle in which each response shows up
  be_t         log_be [$];
  addr_t       log_addr [$];
  logic        err_en;
  logic [3:0]  err_word;
  string       test_name;
  int          test_errors;
  int          check_count = 0;
  int          error_count = 0;
  word_t       resp_rdata;
  logic [31:0] resp_flags;        // rdata_valid, load_err, store_err
  addr_t       resp_last;

  lsu_top lsu_top_inst (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic int access_size(input lsu_type_t t);
    if (t == LSU_TYPE_WORD) return 4;
    if (t == LSU_TYPE_HALF) return 2;
    return 1;
  endfunction

  // little endian bytes from the reference extended per size
  function automatic word_t expect_load(input lsu_type_t t, input logic sext, input addr_t a);
    word_t v;
    v = {ref_bytes[a + 3], ref_bytes[a + 2], ref_bytes[a + 1], ref_bytes[a]};
    if (t == LSU_TYPE_WORD) return v;
    if (t == LSU_TYPE_HALF) return {{16{sext & v[15]}}, v[15:0]};
    return {{24{sext & v[7]}}, v[7:0]};
  endfunction

  task automatic fill_memory();
    int a;
    for (a = 0; a < 64; a++) begin
      ref_bytes[a] = 8'(a * 37 + 5);
      mem_words[a / 4][8 * (a % 4) +: 8] = 8'(a * 37 + 5);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
      error_count++;
    end
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  always begin : memory_model
    int   idx;
    int   ready;
    logic e;
    int   k;
    @(negedge clk_i);
    if (mem_rvalid_i) begin
      void'(resp_data.pop_front());
      void'(resp_err.pop_front());
      void'(resp_ready.pop_front());
    end
    if (mem_req_valid_o && mem_gnt_i) begin
      idx = int'(mem_req_o.addr[5:2]);
      e   = err_en && (mem_req_o.addr[5:2] == err_word);
      log_be.push_back(mem_req_o.be);
      log_addr.push_back(mem_req_o.addr);
      if (mem_req_o.we && !e) begin
        for (k = 0; k < 4; k++) begin
          if (mem_req_o.be[k]) mem_words[idx][8 * k +: 8] = mem_req_o.wdata[8 * k +: 8];
        end
      end
      ready = cyc + 1 + int'(random_bits(2) % 3);   // 1 to 3 cycles after grant
      if (ready <= last_ready) ready = last_ready + 1; // keep order
      last_ready = ready;
      resp_data.push_back(mem_req_o.we ? 32'h0 : mem_words[idx]);
      resp_err.push_back(e);
      resp_ready.push_back(ready);
      gnt_wait = int'(random_bits(2) % 3);
    end else if (mem_req_valid_o && gnt_wait > 0) begin
      gnt_wait--;
    end
    @(posedge clk_i);
    #1;
    cyc++;
    mem_gnt_i = (gnt_wait == 0);
    if (resp_ready.size() > 0 && resp_ready[0] <= cyc) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = resp_data[0];
      mem_err_i    = resp_err[0];
    end else begin
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
      mem_err_i    = 1'b0;
    end
  end

  //////////////////////////////
  // core side
  //////////////////////////////

  // entered and left 1 ns after a rising edge
  task automatic run_access(input logic we, input lsu_type_t t, input logic sext,
                            input addr_t a, input word_t wd);
    int   cycles;
    logic done_seen;
    logic got;
    log_be.delete();
    log_addr.delete();
    lsu_req_i.we        = we;
    lsu_req_i.data_type = t;
    lsu_req_i.sign_ext  = sext;
    lsu_req_i.addr      = a;
    lsu_req_i.wdata     = wd;
    lsu_valid_i         = 1'b1;
    cycles    = 0;
    done_seen = 1'b0;
    got       = 1'b0;
    while (!got && cycles < 50) begin
      @(negedge clk_i);
      if (lsu_resp_valid_o) begin
        got        = 1'b1;
        resp_rdata = lsu_rdata_o;
        resp_flags = {29'd0, lsu_rdata_valid_o, load_err_o, store_err_o};
        resp_last  = addr_last_o;
      end
      if (lsu_req_done_o) done_seen = 1'b1;
      @(posedge clk_i);
      #1;
      if (done_seen) lsu_valid_i = 1'b0;
      cycles++;
    end
    if (!got) begin
      error_count++;
      $display("timeout: no response from the DUT for address %h in %s", a, test_name);
      $display("Checks failed");
      $finish;
    end else begin
      check_value("req_done before response", 32'h1, {31'd0, done_seen});
    end
  endtask

  task automatic do_store(input lsu_type_t t, input addr_t a, input word_t wd);
    int k;
    run_access(1'b1, t, 1'b0, a, wd);
    check_value("store flags", 32'h0, resp_flags);
    for (k = 0; k < access_size(t); k++) ref_bytes[a + k] = wd[8 * k +: 8];
  endtask

  task automatic do_load(input lsu_type_t t, input logic sext, input addr_t a);
    run_access(1'b0, t, sext, a, random_bits(32)); // wdata ignored on loads
    check_value("load flags", 32'h4, resp_flags);
    check_value("load data", expect_load(t, sext, a), resp_rdata);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d mismatches", test_name, error_count - test_errors);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin : main
    int        i;
    lsu_type_t t;
    addr_t     a;
    logic      we;
    logic      sext;
    rst_ni       = 1'b0;
    lsu_req_i    = '0;
    lsu_valid_i  = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_err_i    = 1'b0;
    err_en       = 1'b0;
    err_word     = 4'd0;
    fill_memory();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    start_test("reset_values");
    @(negedge clk_i);
    check_value("outputs after reset", 32'h0,
                {25'd0, mem_req_valid_o, lsu_req_done_o, lsu_resp_valid_o,
                 lsu_rdata_valid_o, load_err_o, store_err_o, busy_o});
    @(posedge clk_i);
    #1;
    end_test();

    start_test("aligned_word");
    do_store(LSU_TYPE_WORD, 32'h20, 32'hdead_beef);
    check_value("request count", 32'd1, 32'(log_be.size()));
    check_value("store be", 32'hf, 32'(log_be[0]));
    do_load(LSU_TYPE_WORD, 1'b0, 32'h20);
    end_test();

    start_test("byte_half_loads");
    for (i = 0; i < 4; i++) begin
      do_load(LSU_TYPE_BYTE, 1'b0, 32'h08 + i);
      do_load(LSU_TYPE_BYTE, 1'b1, 32'h08 + i);
      do_load(LSU_TYPE_HALF, 1'b0, 32'h08 + i);
      do_load(LSU_TYPE_HALF, 1'b1, 32'h08 + i);
    end
    end_test();

    start_test("split_stores");
    do_store(LSU_TYPE_WORD, 32'h31, 32'h1234_5678);
    check_value("request count", 32'd2, 32'(log_be.size()));
    check_value("first be", 32'he, 32'(log_be[0]));
    check_value("second be", 32'h1, 32'(log_be[1]));
    check_value("second address", 32'h34, log_addr[1]);
    do_load(LSU_TYPE_WORD, 1'b0, 32'h31);
    do_load(LSU_TYPE_WORD, 1'b0, 32'h30); // neighbours below and above
    do_load(LSU_TYPE_WORD, 1'b0, 32'h34);
    do_store(LSU_TYPE_HALF, 32'h2b, 32'h0000_a5c3);
    check_value("request count", 32'd2, 32'(log_be.size()));
    check_value("first be", 32'h8, 32'(log_be[0]));
    check_value("second be", 32'h1, 32'(log_be[1]));
    do_load(LSU_TYPE_HALF, 1'b1, 32'h2b);
    do_load(LSU_TYPE_WORD, 1'b0, 32'h28);
    do_load(LSU_TYPE_WORD, 1'b0, 32'h2c);
    end_test();

    start_test("bus_errors");
    err_en   = 1'b1;
    err_word = 4'd6;
    run_access(1'b0, LSU_TYPE_WORD, 1'b0, 32'h18, 32'h0);
    check_value("load error flags", 32'h2, resp_flags);
    check_value("load error address", 32'h18, resp_last);
    err_word = 4'd5;                    // second half of the split store
    run_access(1'b1, LSU_TYPE_WORD, 1'b0, 32'h11, 32'hcafe_f00d);
    check_value("store error flags", 32'h1, resp_flags);
    check_value("store error address", 32'h14, resp_last);
    err_en = 1'b0;
    fill_memory();
    end_test();

    start_test("random");
    for (i = 0; i < 40; i++) begin
      t    = lsu_type_t'(random_bits(2));
      a    = addr_t'(int'(random_bits(4) % 15) * 4) + random_bits(2); // stay below word 15
      we   = (random_bits(1) != 0);
      sext = (random_bits(1) != 0);
      if (we) begin
        do_store(t, a, random_bits(32));
      end else begin
        do_load(t, sext, a);
      end
    end
    end_test();

    $display("6 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/lsu_pkg.sv
verilog/lsu_ctrl.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the lsu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb \
  -f compile.f -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/lsu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

/* verilog/lsu_ctrl.sv */
// lsu controller: request FSM, misaligned split control, error and last-address registers
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  lsu_req_t lsu_req_i,
  input  logic     lsu_valid_i,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  logic     mem_err_i,
  output logic     mem_req_valid_o,
  output addr_t    mem_addr_o,
  output logic     second_part_o,
  output logic     ctrl_update_o,
  output logic     rdata_update_o,
  output logic     lsu_req_done_o,
  output logic     lsu_resp_valid_o,
  output logic     lsu_rdata_valid_o,
  output logic     load_err_o,
  output logic     store_err_o,
  output addr_t    addr_last_o,
  output logic     busy_o
);

  lsu_fsm_e state_q, state_d;

  offset_t offset;
  logic    split_access;   // access needs two word-aligned requests
  logic    mis_q, mis_d;   // second half is being issued
  logic    err_q, err_d;   // error seen on the first half
  logic    we_q;           // direction of the access in flight
  logic    addr_incr;      // present the second address
  logic    addr_update;
  logic    go;             // new request accepted in idle
  logic    resp_err;
  addr_t   addr_next;
  addr_t   addr_last_d, addr_last_q;

  assign offset = lsu_req_i.addr[1:0];

  assign split_access =
      ((lsu_req_i.data_type == LSU_TYPE_WORD) && (offset != 2'b00)) ||
      ((lsu_req_i.data_type == LSU_TYPE_HALF) && (offset == 2'b11));

  // second half always lands in the next word
  assign addr_next   = lsu_req_i.addr + 32'd4;
  assign mem_addr_o  = addr_incr ? addr_next : lsu_req_i.addr;
  assign addr_last_d = addr_incr ? {addr_next[31:2], 2'b00} : lsu_req_i.addr;

  //////////////////////////////
  // request FSM
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    mis_d           = mis_q;
    err_d           = err_q;
    mem_req_valid_o = 1'b0;
    addr_incr       = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    go              = 1'b0;

    unique case (state_q)
      LS_IDLE: begin
        if (lsu_valid_i) begin
          mem_req_valid_o = 1'b1;
          err_d           = 1'b0;
          go              = 1'b1;
          if (mem_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            mis_d         = split_access;
            state_d       = split_access ? LS_WAIT_RVALID_MIS : LS_IDLE;
          end else begin
            state_d       = split_access ? LS_WAIT_GNT_MIS : LS_WAIT_GNT;
          end
        end
      end

      LS_WAIT_GNT_MIS: begin
        mem_req_valid_o = 1'b1;
        if (mem_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          mis_d         = 1'b1;
          state_d       = LS_WAIT_RVALID_MIS;
        end
      end

      LS_WAIT_RVALID_MIS: begin
        mem_req_valid_o = 1'b1; // second half goes out right away
        addr_incr       = 1'b1;
        if (mem_rvalid_i) begin
          err_d          = mem_err_i;
          rdata_update_o = ~we_q;
          // keep the first address if the first half failed
          addr_update    = mem_gnt_i & ~mem_err_i;
          mis_d          = ~mem_gnt_i;
          state_d        = mem_gnt_i ? LS_IDLE : LS_WAIT_GNT;
        end else if (mem_gnt_i) begin
          mis_d   = 1'b0;
          state_d = LS_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      LS_WAIT_GNT: begin
        mem_req_valid_o = 1'b1;
        addr_incr       = mis_q;
        if (mem_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~err_q;
          mis_d         = 1'b0;
          state_d       = LS_IDLE;
        end
      end

      LS_WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr = 1'b1; // second address still needed for addr_last
        if (mem_rvalid_i) begin
          err_d          = mem_err_i;
          addr_update    = ~mem_err_i;
          rdata_update_o = ~we_q;
          state_d        = LS_IDLE;
        end
      end

      default: state_d = LS_IDLE;
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= LS_IDLE;
      mis_q       <= 1'b0;
      err_q       <= 1'b0;
      we_q        <= 1'b0;
      addr_last_q <= '0;
    end else begin
      state_q <= state_d;
      mis_q   <= mis_d;
      err_q   <= err_d;
      if (ctrl_update_o) begin
        we_q <= lsu_req_i.we;
      end
      if (addr_update) begin
        addr_last_q <= addr_last_d;
      end
    end
  end

  //////////////////////////////
  // core side strobes
  //////////////////////////////

  // done at the end of the last address phase
  assign lsu_req_done_o = (go | (state_q != LS_IDLE)) & (state_d == LS_IDLE);

  // a split access answers only on its second response
  assign resp_err          = err_q | mem_err_i;
  assign lsu_resp_valid_o  = mem_rvalid_i & (state_q == LS_IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & resp_err & we_q;

  assign second_part_o = mis_q;
  assign addr_last_o   = addr_last_q; // failing address for the trap handler
  assign busy_o        = (state_q != LS_IDLE);

endmodule

/* verilog/lsu_load_align.sv */
// load aligner: load control registers, partial-word register, realignment, sign extension
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  lsu_req_t lsu_req_i,
  input  logic     ctrl_update_i,
  input  logic     rdata_update_i,
  input  word_t    mem_rdata_i,
  output word_t    rdata_o
);

  lsu_type_t   type_q;
  offset_t     offset_q;
  logic        sign_ext_q;
  logic [23:0] rdata_q;     // upper three bytes of the first word

  word_t       word_ext;    // word joined across the boundary
  word_t       shifted;
  logic [15:0] half;
  logic [7:0]  byte_d;
  word_t       half_ext;
  word_t       byte_ext;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      type_q     <= LSU_TYPE_WORD;
      offset_q   <= '0;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      type_q     <= lsu_req_i.data_type;
      offset_q   <= lsu_req_i.addr[1:0];
      sign_ext_q <= lsu_req_i.sign_ext;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= mem_rdata_i[31:8];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  always_comb begin
    unique case (offset_q)
      2'b00: word_ext = mem_rdata_i;
      2'b01: word_ext = {mem_rdata_i[7:0], rdata_q[23:0]};
      2'b10: word_ext = {mem_rdata_i[15:0], rdata_q[23:8]};
      2'b11: word_ext = {mem_rdata_i[23:0], rdata_q[23:16]};
    endcase
  end

  // bytes and halfwords inside one word come straight from the bus
  assign shifted = mem_rdata_i >> {offset_q, 3'b000};
  assign half    = (offset_q == 2'b11) ? word_ext[15:0] : shifted[15:0]; // split halfword
  assign byte_d  = shifted[7:0];

  assign half_ext = {{16{sign_ext_q & half[15]}}, half};
  assign byte_ext = {{24{sign_ext_q & byte_d[7]}}, byte_d};

  always_comb begin
    unique case (type_q)
      LSU_TYPE_WORD:        rdata_o = word_ext;
      LSU_TYPE_HALF:        rdata_o = half_ext;
      LSU_TYPE_BYTE, 2'b11: rdata_o = byte_ext;
    endcase
  end

endmodule

/* verilog/lsu_pkg.sv */
// width typedefs, access-size codes, core and memory request structs, controller states
package lsu_pkg;

  typedef logic [31:0] addr_t;     // byte address
  typedef logic [31:0] word_t;     // data word
  typedef logic [3:0]  be_t;       // one enable per byte lane
  typedef logic [1:0]  offset_t;   // byte offset within a word
  typedef logic [1:0]  lsu_type_t; // access size

  // access size codes, both 10 and 11 mean a byte
  localparam lsu_type_t LSU_TYPE_WORD = 2'b00;
  localparam lsu_type_t LSU_TYPE_HALF = 2'b01;
  localparam lsu_type_t LSU_TYPE_BYTE = 2'b10;

  // request from the core, held until req_done
  typedef struct packed {
    logic      we;
    lsu_type_t data_type;
    logic      sign_ext;
    addr_t     addr;
    word_t     wdata;
  } lsu_req_t;

  // payload toward the data memory
  typedef struct packed {
    addr_t addr;  // always word aligned
    logic  we;
    be_t   be;
    word_t wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    LS_IDLE,
    LS_WAIT_GNT_MIS,              // first half of a split access waits for grant
    LS_WAIT_RVALID_MIS,           // second half issued, first response pending
    LS_WAIT_GNT,                  // single access or second half waits for grant
    LS_WAIT_RVALID_MIS_GNTS_DONE  // both granted, first response pending
  } lsu_fsm_e;

endpackage

/* verilog/lsu_store_align.sv */
// store aligner: byte-enable generation and store-data lane rotation
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
  input  lsu_req_t lsu_req_i,
  input  logic     second_part_i,
  output be_t      be_o,
  output word_t    wdata_o
);

  offset_t offset;
  word_t   wdata;

  assign offset = lsu_req_i.addr[1:0];
  assign wdata  = lsu_req_i.wdata;

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    unique case (lsu_req_i.data_type)
      LSU_TYPE_WORD: begin
        if (!second_part_i) begin
          be_o = 4'b1111 << offset;          // lanes from offset upward
        end else begin
          be_o = ~(4'b1111 << offset);       // the rest in the next word
        end
      end
      LSU_TYPE_HALF: begin
        if (!second_part_i) begin
          be_o = be_t'(4'b0011 << offset);   // offset 3 keeps only the top lane
        end else begin
          be_o = 4'b0001;                    // only reached from offset 3
        end
      end
      default: be_o = 4'b0001 << offset;     // byte
    endcase
  end

  //////////////////////////////
  // lane rotation
  //////////////////////////////

  // rotate left by the offset in bytes, bytes wrapping past lane 3 belong to the second half
  always_comb begin
    unique case (offset)
      2'b00: wdata_o = wdata;
      2'b01: wdata_o = {wdata[23:0], wdata[31:24]};
      2'b10: wdata_o = {wdata[15:0], wdata[31:16]};
      2'b11: wdata_o = {wdata[7:0], wdata[31:8]};
    endcase
  end

endmodule

/* verilog/lsu_top.sv */
// lsu top level: controller, store aligner and load aligner wired to core and memory ports
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // core side
  input  lsu_req_t lsu_req_i,
  input  logic     lsu_valid_i,
  output logic     lsu_req_done_o,
  output logic     lsu_resp_valid_o,
  output logic     lsu_rdata_valid_o,
  output word_t    lsu_rdata_o,
  output logic     load_err_o,
  output logic     store_err_o,
  output addr_t    addr_last_o,
  output logic     busy_o,

  // memory side
  output logic     mem_req_valid_o,
  output mem_req_t mem_req_o,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  word_t    mem_rdata_i,
  input  logic     mem_err_i
);

  addr_t mem_addr;
  logic  second_part;
  logic  ctrl_update;
  logic  rdata_update;
  be_t   be;
  word_t wdata;

  lsu_ctrl lsu_ctrl_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_valid_i       (lsu_valid_i),
    .mem_gnt_i         (mem_gnt_i),
    .mem_rvalid_i      (mem_rvalid_i),
    .mem_err_i         (mem_err_i),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_addr_o        (mem_addr),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .addr_last_o       (addr_last_o),
    .busy_o            (busy_o)
  );

  lsu_store_align lsu_store_align_inst (
    .lsu_req_i     (lsu_req_i),
    .second_part_i (second_part),
    .be_o          (be),
    .wdata_o       (wdata)
  );

  lsu_load_align lsu_load_align_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .mem_rdata_i    (mem_rdata_i),
    .rdata_o        (lsu_rdata_o)
  );

  // memory only sees word addresses
  assign mem_req_o.addr  = {mem_addr[31:2], 2'b00};
  assign mem_req_o.we    = lsu_req_i.we;
  assign mem_req_o.be    = be;
  assign mem_req_o.wdata = wdata;

endmodule
